// ==== logic/emesh_pkg.sv ====
package emesh_pkg;

  // One eMesh transaction, 104 bits, write bit on top
  typedef struct packed {
    logic        write;
    logic [1:0]  datamode;
    logic [4:0]  ctrlmode;
    logic [31:0] dstaddr;
    logic [31:0] data;
    logic [31:0] srcaddr;
  } emesh_packet_t;

  // Destination stream of a packet
  typedef enum logic [1:0] {
    PKT_WRITE,
    PKT_READ_REQ,
    PKT_READ_RESP
  } pkt_class_e;

  // AXI channel machines
  // Write side uses IDLE and RESP, read side uses IDLE and DATA
  typedef enum logic [1:0] {
    AXI_IDLE,
    AXI_RESP,
    AXI_DATA
  } axi_state_e;

  // Register map
  localparam logic [7:0] REG_CTRL       = 8'h00;
  localparam logic [7:0] REG_TABLE_BASE = 8'h40;
  localparam int         TABLE_ENTRIES  = 16;

  // Remap configuration seen by the remapper
  // Entry picked by dstaddr[31:28], replaces dstaddr[31:20]
  typedef struct packed {
    logic                               enable;
    logic [TABLE_ENTRIES-1:0][11:0]     entries;
  } remap_cfg_t;

endpackage

// ==== logic/erx_regs.sv ====
module erx_regs
  import emesh_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic [7:0]  s_axi_awaddr,
  input  logic        s_axi_awvalid,
  output logic        s_axi_awready,
  input  logic [31:0] s_axi_wdata,
  input  logic [3:0]  s_axi_wstrb,
  input  logic        s_axi_wvalid,
  output logic        s_axi_wready,
  output logic [1:0]  s_axi_bresp,
  output logic        s_axi_bvalid,
  input  logic        s_axi_bready,
  input  logic [7:0]  s_axi_araddr,
  input  logic        s_axi_arvalid,
  output logic        s_axi_arready,
  output logic [31:0] s_axi_rdata,
  output logic [1:0]  s_axi_rresp,
  output logic        s_axi_rvalid,
  input  logic        s_axi_rready,
  output remap_cfg_t  cfg
);

  axi_state_e  wr_state;
  axi_state_e  rd_state;
  logic        aw_done;
  logic        w_done;
  logic        wr_commit;
  logic [7:0]  aw_addr_q;
  logic [31:0] w_data_q;
  logic [3:0]  w_strb_q;
  logic [31:0] rd_word;

  // Control word, byte address bits 1:0 ignored
  function automatic logic hit_ctrl(input logic [7:0] addr);
    return addr[7:2] == REG_CTRL[7:2];
  endfunction

  // Sixteen table words fill 0x40 to 0x7C
  function automatic logic hit_table(input logic [7:0] addr);
    return addr[7:6] == REG_TABLE_BASE[7:6];
  endfunction

  // Address and data accepted independently, each once per write
  assign s_axi_awready = (wr_state == AXI_IDLE) && !aw_done;
  assign s_axi_wready  = (wr_state == AXI_IDLE) && !w_done;
  assign s_axi_bvalid  = (wr_state == AXI_RESP);
  assign s_axi_bresp   = 2'b00;

  // Both halves in hand
  assign wr_commit = (wr_state == AXI_IDLE) && aw_done && w_done;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_state <= AXI_IDLE;
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
    end
    else
    begin
      case (wr_state)
        AXI_IDLE:
        begin
          if (s_axi_awvalid && s_axi_awready)
            aw_done <= 1'b1;
          if (s_axi_wvalid && s_axi_wready)
            w_done <= 1'b1;
          if (wr_commit)
          begin
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            wr_state <= AXI_RESP;
          end
        end
        AXI_RESP:
        begin
          // Response always OKAY
          if (s_axi_bready)
            wr_state <= AXI_IDLE;
        end
        default:
          wr_state <= AXI_IDLE;
      endcase
    end
  end

  // Captured address and data
  always_ff @(posedge clk)
  begin
    if (s_axi_awvalid && s_axi_awready)
      aw_addr_q <= s_axi_awaddr;
    if (s_axi_wvalid && s_axi_wready)
    begin
      w_data_q <= s_axi_wdata;
      w_strb_q <= s_axi_wstrb;
    end
  end

  // Storage update, same edge that raises bvalid
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      cfg <= '0;
    else if (wr_commit)
    begin
      if (hit_ctrl(aw_addr_q))
      begin
        if (w_strb_q[0])
          cfg.enable <= w_data_q[0];
      end
      else if (hit_table(aw_addr_q))
      begin
        // Entry is 12 bits wide, spans bytes 0 and 1
        if (w_strb_q[0])
          cfg.entries[aw_addr_q[5:2]][7:0] <= w_data_q[7:0];
        if (w_strb_q[1])
          cfg.entries[aw_addr_q[5:2]][11:8] <= w_data_q[11:8];
      end
    end
  end

  // Readback mux, unmapped gives zero
  always_comb
  begin
    rd_word = '0;
    if (hit_ctrl(s_axi_araddr))
      rd_word[0] = cfg.enable;
    else if (hit_table(s_axi_araddr))
      rd_word[11:0] = cfg.entries[s_axi_araddr[5:2]];
  end

  assign s_axi_arready = (rd_state == AXI_IDLE);
  assign s_axi_rvalid  = (rd_state == AXI_DATA);
  assign s_axi_rresp   = 2'b00;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rd_state <= AXI_IDLE;
    else if (rd_state == AXI_IDLE)
    begin
      if (s_axi_arvalid)
        rd_state <= AXI_DATA;
    end
    else if (s_axi_rready)
      rd_state <= AXI_IDLE;
  end

  // Read data sampled with the address
  always_ff @(posedge clk)
  begin
    if (s_axi_arvalid && s_axi_arready)
      s_axi_rdata <= rd_word;
  end

endmodule

// ==== logic/erx_remap.sv ====
module erx_remap
  import emesh_pkg::*;
(
  input  logic          clk,
  input  logic          arst_n,
  input  remap_cfg_t    cfg,
  input  logic          in_access,
  input  emesh_packet_t in_packet,
  output logic          in_wait,
  input  logic          rd_wait,
  input  logic          wr_wait,
  output logic          mmu_access,
  output emesh_packet_t mmu_packet
);

  logic          held_q;
  logic          stall;
  emesh_packet_t remapped;

  // Address translation
  // Top nibble picks the entry, entry replaces the top 12 bits
  always_comb
  begin
    remapped = in_packet;
    if (cfg.enable)
      remapped.dstaddr[31:20] = cfg.entries[in_packet.dstaddr[31:28]];
  end

  // Held item blocked by the wait of its own kind
  assign stall = held_q && (mmu_packet.write ? wr_wait : rd_wait);

  // Source sees the stall directly
  assign in_wait = stall;

  // Hand over only when the distributor can take it
  assign mmu_access = held_q && !stall;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      held_q <= 1'b0;
    else if (!stall)
      held_q <= in_access;
  end

  // Packet register, frozen while stalled
  always_ff @(posedge clk)
  begin
    if (!stall && in_access)
      mmu_packet <= remapped;
  end

endmodule

// ==== logic/erx_disty.sv ====
module erx_disty
  import emesh_pkg::*;
#(
  parameter logic [11:0] read_tag = 12'h810
)
(
  input  logic          clk,
  input  logic          arst_n,
  input  logic          mmu_access,
  input  emesh_packet_t mmu_packet,
  input  logic          dma_access,
  input  emesh_packet_t dma_packet,
  output logic          dma_wait,
  output logic          rd_wait,
  output logic          wr_wait,
  output logic          wr_access,
  output emesh_packet_t wr_packet,
  output logic          rd_access,
  output emesh_packet_t rd_packet,
  output logic          rr_access,
  output emesh_packet_t rr_packet,
  input  logic          wr_fifo_wait,
  input  logic          rd_fifo_wait,
  input  logic          rr_fifo_wait
);

  pkt_class_e mmu_class;
  logic       mesh_read;

  // Reads are requests
  // A write carrying the read tag is a response
  function automatic pkt_class_e classify(input emesh_packet_t pkt);
    if (!pkt.write)
      return PKT_READ_REQ;
    else if (pkt.dstaddr[31:20] == read_tag)
      return PKT_READ_RESP;
    else
      return PKT_WRITE;
  endfunction

  assign mmu_class = classify(mmu_packet);
  assign mesh_read = mmu_access && (mmu_class == PKT_READ_REQ);

  // Read request stream, mesh ahead of DMA
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rd_access <= 1'b0;
    else
      rd_access <= mesh_read || dma_access;
  end

  always_ff @(posedge clk)
  begin
    if (mesh_read)
      rd_packet <= mmu_packet;
    else if (dma_access)
      rd_packet <= dma_packet;
  end

  // Write and response streams from the mesh only
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_access <= 1'b0;
      rr_access <= 1'b0;
    end
    else
    begin
      wr_access <= mmu_access && (mmu_class == PKT_WRITE);
      rr_access <= mmu_access && (mmu_class == PKT_READ_RESP);
    end
  end

  // One register serves both write-type streams
  always_ff @(posedge clk)
  begin
    if (mmu_access && mmu_packet.write)
      wr_packet <= mmu_packet;
  end

  assign rr_packet = wr_packet;

  // Back-pressure toward the remapper and DMA
  assign rd_wait  = rd_fifo_wait;
  assign wr_wait  = wr_fifo_wait | rr_fifo_wait;
  assign dma_wait = rd_fifo_wait | mesh_read;

endmodule

// ==== logic/erx_fifo.sv ====
module erx_fifo
  import emesh_pkg::*;
#(
  parameter int fifo_depth = 8
)
(
  input  logic          clk,
  input  logic          arst_n,
  input  logic          in_access,
  input  emesh_packet_t in_packet,
  output logic          in_wait,
  output logic          out_access,
  output emesh_packet_t out_packet,
  input  logic          out_wait
);

  localparam int ptr_w = $clog2(fifo_depth);
  localparam int cnt_w = ptr_w + 1;
  // Two free slots kept for items in flight upstream
  localparam logic [cnt_w-1:0] wait_level = cnt_w'(fifo_depth - 2);

  emesh_packet_t    mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             out_ready;
  logic             mem_empty;
  logic             bypass;
  logic             push;
  logic             pop;

  // Output register free or draining this cycle
  assign out_ready = !out_access || !out_wait;
  assign mem_empty = (count == '0);
  // Empty FIFO feeds the output register directly
  assign bypass    = in_access && mem_empty && out_ready;
  assign push      = in_access && !bypass;
  assign pop       = out_ready && !mem_empty;

  assign in_wait = (count >= wait_level);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      out_access <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + cnt_w'(push) - cnt_w'(pop);
      // Held while the consumer waits
      if (out_ready)
        out_access <= !mem_empty || in_access;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_packet;
  end

  // Oldest entry first, else the incoming packet
  always_ff @(posedge clk)
  begin
    if (pop)
      out_packet <= mem[rd_ptr];
    else if (bypass)
      out_packet <= in_packet;
  end

endmodule

// ==== logic/erx_core.sv ====
module erx_core
  import emesh_pkg::*;
#(
  parameter logic [11:0] read_tag   = 12'h810,
  parameter int          fifo_depth = 8
)
(
  input  logic          clk,
  input  logic          arst_n,
  input  logic [7:0]    s_axi_awaddr,
  input  logic          s_axi_awvalid,
  output logic          s_axi_awready,
  input  logic [31:0]   s_axi_wdata,
  input  logic [3:0]    s_axi_wstrb,
  input  logic          s_axi_wvalid,
  output logic          s_axi_wready,
  output logic [1:0]    s_axi_bresp,
  output logic          s_axi_bvalid,
  input  logic          s_axi_bready,
  input  logic [7:0]    s_axi_araddr,
  input  logic          s_axi_arvalid,
  output logic          s_axi_arready,
  output logic [31:0]   s_axi_rdata,
  output logic [1:0]    s_axi_rresp,
  output logic          s_axi_rvalid,
  input  logic          s_axi_rready,
  input  logic          in_access,
  input  emesh_packet_t in_packet,
  output logic          in_wait,
  input  logic          dma_access,
  input  emesh_packet_t dma_packet,
  output logic          dma_wait,
  output logic          wr_access,
  output emesh_packet_t wr_packet,
  input  logic          wr_wait,
  output logic          rd_access,
  output emesh_packet_t rd_packet,
  input  logic          rd_wait,
  output logic          rr_access,
  output emesh_packet_t rr_packet,
  input  logic          rr_wait
);

  remap_cfg_t    cfg;
  logic          mmu_access;
  emesh_packet_t mmu_packet;
  // Distributor waits back to the remapper
  logic          mmu_rd_wait;
  logic          mmu_wr_wait;
  // Distributor to FIFO links
  logic          wr_fifo_access;
  emesh_packet_t wr_fifo_packet;
  logic          wr_fifo_wait;
  logic          rd_fifo_access;
  emesh_packet_t rd_fifo_packet;
  logic          rd_fifo_wait;
  logic          rr_fifo_access;
  emesh_packet_t rr_fifo_packet;
  logic          rr_fifo_wait;

  erx_regs u_erx_regs (
    .clk           (clk),
    .arst_n        (arst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .cfg           (cfg)
  );

  erx_remap u_erx_remap (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .in_access  (in_access),
    .in_packet  (in_packet),
    .in_wait    (in_wait),
    .rd_wait    (mmu_rd_wait),
    .wr_wait    (mmu_wr_wait),
    .mmu_access (mmu_access),
    .mmu_packet (mmu_packet)
  );

  erx_disty #(
    .read_tag (read_tag)
  ) u_erx_disty (
    .clk          (clk),
    .arst_n       (arst_n),
    .mmu_access   (mmu_access),
    .mmu_packet   (mmu_packet),
    .dma_access   (dma_access),
    .dma_packet   (dma_packet),
    .dma_wait     (dma_wait),
    .rd_wait      (mmu_rd_wait),
    .wr_wait      (mmu_wr_wait),
    .wr_access    (wr_fifo_access),
    .wr_packet    (wr_fifo_packet),
    .rd_access    (rd_fifo_access),
    .rd_packet    (rd_fifo_packet),
    .rr_access    (rr_fifo_access),
    .rr_packet    (rr_fifo_packet),
    .wr_fifo_wait (wr_fifo_wait),
    .rd_fifo_wait (rd_fifo_wait),
    .rr_fifo_wait (rr_fifo_wait)
  );

  // Write stream queue
  erx_fifo #(
    .fifo_depth (fifo_depth)
  ) u_wr_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_access  (wr_fifo_access),
    .in_packet  (wr_fifo_packet),
    .in_wait    (wr_fifo_wait),
    .out_access (wr_access),
    .out_packet (wr_packet),
    .out_wait   (wr_wait)
  );

  // Read request queue, mesh and DMA
  erx_fifo #(
    .fifo_depth (fifo_depth)
  ) u_rd_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_access  (rd_fifo_access),
    .in_packet  (rd_fifo_packet),
    .in_wait    (rd_fifo_wait),
    .out_access (rd_access),
    .out_packet (rd_packet),
    .out_wait   (rd_wait)
  );

  // Read response queue
  erx_fifo #(
    .fifo_depth (fifo_depth)
  ) u_rr_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_access  (rr_fifo_access),
    .in_packet  (rr_fifo_packet),
    .in_wait    (rr_fifo_wait),
    .out_access (rr_access),
    .out_packet (rr_packet),
    .out_wait   (rr_wait)
  );

endmodule

// ==== testbench/erx_core_asserts.sv ====
module erx_core_asserts
  import emesh_pkg::*;
(
  input logic          clk,
  input logic          arst_n,
  input logic          mmu_access,
  input emesh_packet_t mmu_packet,
  input logic          dma_access,
  input logic          dma_wait,
  input logic          wr_access,
  input logic          rd_access,
  input logic          rr_access
);

  // Stream registers cleared while reset is held
  reset_quiet: assert property (@(posedge clk)
    !arst_n |-> !(wr_access || rd_access || rr_access))
    else $error("stream access high during reset");

  // Presented mesh packet lands in exactly one stream
  // A DMA read taken on the same edge may add the rd stream
  mesh_one_stream: assert property (@(posedge clk) disable iff (!arst_n)
    mmu_access |=> $onehot({wr_access, rr_access, rd_access && !$past(dma_access)}))
    else $error("mesh packet sent to no stream or to several");

  // Mesh reads block the DMA port, no DMA read collides with them
  mesh_read_priority: assert property (@(posedge clk) disable iff (!arst_n)
    (mmu_access && !mmu_packet.write) |-> (dma_wait && !dma_access))
    else $error("DMA read taken while a mesh read is presented");

endmodule

bind erx_disty erx_core_asserts u_erx_core_asserts (
  .clk        (clk),
  .arst_n     (arst_n),
  .mmu_access (mmu_access),
  .mmu_packet (mmu_packet),
  .dma_access (dma_access),
  .dma_wait   (dma_wait),
  .wr_access  (wr_access),
  .rd_access  (rd_access),
  .rr_access  (rr_access)
);

// ==== testbench/tb_erx_core.sv ====
module tb_erx_core
  import emesh_pkg::*;
#(
  parameter int start_seed = 82
);

  localparam logic [11:0] read_tag    = 12'h810;
  localparam int          fifo_depth  = 8;
  localparam int          n_mesh      = 300;
  localparam int          n_dma       = 150;
  // Four mesh phases, two with DMA
  localparam int          cycle_limit = 20 * (4 * n_mesh + 2 * n_dma) + 2000;

  logic          clk;
  logic          arst_n;
  logic [7:0]    s_axi_awaddr;
  logic          s_axi_awvalid;
  logic          s_axi_awready;
  logic [31:0]   s_axi_wdata;
  logic [3:0]    s_axi_wstrb;
  logic          s_axi_wvalid;
  logic          s_axi_wready;
  logic [1:0]    s_axi_bresp;
  logic          s_axi_bvalid;
  logic          s_axi_bready;
  logic [7:0]    s_axi_araddr;
  logic          s_axi_arvalid;
  logic          s_axi_arready;
  logic [31:0]   s_axi_rdata;
  logic [1:0]    s_axi_rresp;
  logic          s_axi_rvalid;
  logic          s_axi_rready;
  logic          in_access;
  emesh_packet_t in_packet;
  logic          in_wait;
  logic          dma_access;
  emesh_packet_t dma_packet;
  logic          dma_wait;
  logic          wr_access;
  emesh_packet_t wr_packet;
  logic          wr_wait;
  logic          rd_access;
  emesh_packet_t rd_packet;
  logic          rd_wait;
  logic          rr_access;
  emesh_packet_t rr_packet;
  logic          rr_wait;

  int            seed;
  int            errors;
  int            checks;
  int            cycles;
  logic          wait_mode;
  // Register mirror
  logic          enable_mirror;
  logic [11:0]   table_mirror [TABLE_ENTRIES];
  // Expected packets per stream, slot 0 wr, 1 rd, 2 rr
  emesh_packet_t exp_q [3][$];
  logic          held_valid [3];
  emesh_packet_t held_pkt [3];

  erx_core #(
    .read_tag   (read_tag),
    .fifo_depth (fifo_depth)
  ) u_erx_core (
    .clk           (clk),
    .arst_n        (arst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .in_access     (in_access),
    .in_packet     (in_packet),
    .in_wait       (in_wait),
    .dma_access    (dma_access),
    .dma_packet    (dma_packet),
    .dma_wait      (dma_wait),
    .wr_access     (wr_access),
    .wr_packet     (wr_packet),
    .wr_wait       (wr_wait),
    .rd_access     (rd_access),
    .rd_packet     (rd_packet),
    .rd_wait       (rd_wait),
    .rr_access     (rr_access),
    .rr_packet     (rr_packet),
    .rr_wait       (rr_wait)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic in_table(input logic [7:0] addr);
    return int'(addr) >= int'(REG_TABLE_BASE) &&
           int'(addr) < int'(REG_TABLE_BASE) + 4 * TABLE_ENTRIES;
  endfunction

  function automatic logic [3:0] table_index(input logic [7:0] addr);
    return 4'((int'(addr) - int'(REG_TABLE_BASE)) / 4);
  endfunction

  // Register semantics under byte strobes
  task automatic update_mirror(input logic [7:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
    if (int'(addr) < int'(REG_CTRL) + 4)
    begin
      if (strb[0])
        enable_mirror = data[0];
    end
    else if (in_table(addr))
    begin
      if (strb[0])
        table_mirror[table_index(addr)][7:0] = data[7:0];
      if (strb[1])
        table_mirror[table_index(addr)][11:8] = data[11:8];
    end
  endtask

  function automatic logic [31:0] expected_readback(input logic [7:0] addr);
    if (int'(addr) < int'(REG_CTRL) + 4)
      return {31'd0, enable_mirror};
    else if (in_table(addr))
      return {20'd0, table_mirror[table_index(addr)]};
    else
      return 32'd0;
  endfunction

  function automatic emesh_packet_t expected_remap(input emesh_packet_t pkt);
    emesh_packet_t q;
    q = pkt;
    if (enable_mirror)
      q.dstaddr[31:20] = table_mirror[pkt.dstaddr[31:28]];
    return q;
  endfunction

  function automatic string stream_name(input logic [1:0] slot);
    case (slot)
      2'd0: return "wr";
      2'd1: return "rd";
      default: return "rr";
    endcase
  endfunction

  function automatic int pending();
    return exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
  endfunction

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic aw_seen;
    logic w_seen;
    aw_seen       = 1'b0;
    w_seen        = 1'b0;
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_wvalid  = 1'b1;
    while (!(aw_seen && w_seen))
    begin
      @(negedge clk);
      if (s_axi_awvalid && s_axi_awready)
        aw_seen = 1'b1;
      if (s_axi_wvalid && s_axi_wready)
        w_seen = 1'b1;
      @(posedge clk);
      #1;
      if (aw_seen)
        s_axi_awvalid = 1'b0;
      if (w_seen)
        s_axi_wvalid = 1'b0;
    end
    s_axi_bready = 1'b1;
    @(negedge clk);
    while (!s_axi_bvalid)
      @(negedge clk);
    checks++;
    if (s_axi_bresp !== 2'b00)
    begin
      errors++;
      $display("FAIL %0t: write to %h answered bresp %b", $time, addr, s_axi_bresp);
    end
    @(posedge clk);
    #1;
    s_axi_bready = 1'b0;
    update_mirror(addr, data, strb);
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    @(negedge clk);
    while (!s_axi_arready)
      @(negedge clk);
    @(posedge clk);
    #1;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    @(negedge clk);
    while (!s_axi_rvalid)
      @(negedge clk);
    data = s_axi_rdata;
    checks++;
    if (s_axi_rresp !== 2'b00)
    begin
      errors++;
      $display("FAIL %0t: read of %h answered rresp %b", $time, addr, s_axi_rresp);
    end
    @(posedge clk);
    #1;
    s_axi_rready = 1'b0;
  endtask

  // Random writes under random strobes, each read back
  task automatic register_readback();
    logic [31:0] r;
    logic [31:0] data;
    logic [31:0] got;
    logic [7:0]  addr;
    for (int i = 0; i < 40; i++)
    begin
      r    = $random(seed);
      data = $random(seed);
      if (r[3:0] == 4'd0)
        addr = REG_CTRL;
      else
        addr = REG_TABLE_BASE + {2'b00, r[7:4], 2'b00};
      axi_write(addr, data, r[11:8]);
      axi_read(addr, got);
      checks++;
      if (got !== expected_readback(addr))
      begin
        errors++;
        $display("FAIL %0t: register %h read %h, expected %h", $time, addr, got,
                 expected_readback(addr));
      end
    end
    // Holes below the table and above it
    for (int i = 0; i < 8; i++)
    begin
      r    = $random(seed);
      addr = r[8] ? {1'b1, r[6:0]} : 8'h04 + {3'b000, r[4:0]};
      axi_read(addr, got);
      checks++;
      if (got !== 32'd0)
      begin
        errors++;
        $display("FAIL %0t: unmapped %h read %h, expected zero", $time, addr, got);
      end
    end
  endtask

  task automatic program_table();
    logic [31:0] r;
    for (int i = 0; i < TABLE_ENTRIES; i++)
    begin
      r = $random(seed);
      // Tagged destinations keep landing on the response stream
      if (i == int'(read_tag[11:8]))
        r[11:0] = read_tag;
      axi_write(REG_TABLE_BASE + 8'(4 * i), r, 4'hf);
    end
    axi_write(REG_CTRL, 32'h1, 4'hf);
  endtask

  task automatic build_packet(input logic from_dma, output emesh_packet_t pkt);
    logic [31:0] r;
    r            = $random(seed);
    pkt.write    = from_dma ? 1'b0 : r[0];
    pkt.datamode = r[2:1];
    pkt.ctrlmode = r[7:3];
    pkt.dstaddr  = $random(seed);
    pkt.data     = $random(seed);
    pkt.srcaddr  = $random(seed);
    // About a quarter carry the read tag
    if (r[9:8] == 2'b00)
      pkt.dstaddr[31:20] = read_tag;
  endtask

  // Classify after remap, queue on the chosen stream
  task automatic expect_mesh(input emesh_packet_t pkt);
    emesh_packet_t q;
    pkt_class_e    cls;
    logic [1:0]    slot;
    q = expected_remap(pkt);
    if (!q.write)
      cls = PKT_READ_REQ;
    else if (q.dstaddr[31:20] == read_tag)
      cls = PKT_READ_RESP;
    else
      cls = PKT_WRITE;
    slot = cls;
    exp_q[slot].push_back(q);
  endtask

  task automatic drive_out_waits();
    logic [31:0] r;
    r       = $random(seed);
    wr_wait = wait_mode & r[0];
    rd_wait = wait_mode & r[1];
    rr_wait = wait_mode & r[2];
  endtask

  task automatic run_traffic(input int mesh_count, input int dma_count, input logic waits);
    emesh_packet_t pkt;
    logic [31:0]   r;
    logic [1:0]    rd_slot;
    int            mesh_sent;
    int            dma_sent;
    rd_slot   = PKT_READ_REQ;
    mesh_sent = 0;
    dma_sent  = 0;
    wait_mode = waits;
    while (mesh_sent < mesh_count || dma_sent < dma_count)
    begin
      @(posedge clk);
      #1;
      drive_out_waits();
      in_access  = 1'b0;
      dma_access = 1'b0;
      r          = $random(seed);
      // DMA on a shared edge goes ahead of the mesh read still in the remapper
      if (dma_sent < dma_count && !dma_wait && r[1:0] != 2'b00)
      begin
        build_packet(1'b1, pkt);
        dma_packet = pkt;
        dma_access = 1'b1;
        exp_q[rd_slot].push_back(pkt);
        dma_sent++;
      end
      if (mesh_sent < mesh_count && !in_wait && r[3:2] != 2'b00)
      begin
        build_packet(1'b0, pkt);
        in_packet = pkt;
        in_access = 1'b1;
        expect_mesh(pkt);
        mesh_sent++;
      end
    end
    @(posedge clk);
    #1;
    in_access  = 1'b0;
    dma_access = 1'b0;
    while (pending() > 0)
    begin
      @(posedge clk);
      #1;
      drive_out_waits();
    end
    wait_mode = 1'b0;
    drive_out_waits();
    repeat (4) @(posedge clk);
    #1;
  endtask

  // Hold check while waiting, queue compare on each handshake
  task automatic check_output(input logic [1:0] slot, input logic acc, input logic stall,
                              input emesh_packet_t pkt);
    emesh_packet_t want;
    if (held_valid[slot])
    begin
      checks++;
      if (!acc || pkt !== held_pkt[slot])
      begin
        errors++;
        $display("FAIL %0t: %s output changed while its wait was high", $time,
                 stream_name(slot));
      end
    end
    held_valid[slot] = acc && stall;
    held_pkt[slot]   = pkt;
    if (acc && !stall)
    begin
      if (exp_q[slot].size() == 0)
      begin
        errors++;
        $display("ERROR %0t: %s delivered a packet that was never sent", $time,
                 stream_name(slot));
      end
      else
      begin
        want = exp_q[slot].pop_front();
        checks++;
        if (pkt !== want)
        begin
          errors++;
          $display("FAIL %0t: %s got %h, expected %h", $time, stream_name(slot), pkt, want);
        end
      end
    end
  endtask

  // Outputs settle by the falling edge
  always @(negedge clk)
  begin
    if (arst_n)
    begin
      check_output(2'd0, wr_access, wr_wait, wr_packet);
      check_output(2'd1, rd_access, rd_wait, rd_packet);
      check_output(2'd2, rr_access, rr_wait, rr_packet);
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("ERROR: timeout after %0d cycles with %0d packets outstanding", cycles,
               pending());
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Test failures found");
      $finish;
    end
  end

  initial
  begin
    seed          = start_seed;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    wait_mode     = 1'b0;
    enable_mirror = 1'b0;
    for (int i = 0; i < TABLE_ENTRIES; i++)
      table_mirror[i] = 12'd0;
    for (int i = 0; i < 3; i++)
    begin
      held_valid[i] = 1'b0;
      held_pkt[i]   = '0;
    end
    arst_n        = 1'b1;
    s_axi_awaddr  = 8'd0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = 32'd0;
    s_axi_wstrb   = 4'd0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = 8'd0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    in_access     = 1'b0;
    in_packet     = '0;
    dma_access    = 1'b0;
    dma_packet    = '0;
    wr_wait       = 1'b0;
    rd_wait       = 1'b0;
    rr_wait       = 1'b0;
    // Falling edge so the async reset fires at once
    #1;
    arst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    register_readback();
    // Pass-through, then remapped, then DMA mixed in, then output back-pressure
    axi_write(REG_CTRL, 32'h0, 4'hf);
    run_traffic(n_mesh, 0, 1'b0);
    program_table();
    run_traffic(n_mesh, 0, 1'b0);
    run_traffic(n_mesh, n_dma, 1'b0);
    run_traffic(n_mesh, n_dma, 1'b1);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== all.f ====
logic/emesh_pkg.sv
logic/erx_regs.sv
logic/erx_remap.sv
logic/erx_disty.sv
logic/erx_fifo.sv
logic/erx_core.sv
testbench/erx_core_asserts.sv
testbench/tb_erx_core.sv

// ==== Makefile ====
# Verilator build and run for the eMesh receive endpoint

VERILATOR ?= verilator
TOP       ?= tb_erx_core
SEED      ?= 82
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FILELIST  := all.f
SRCS      := $(shell grep -v '^+' $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gstart_seed=$(SEED) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
